// ==== all.f ====
hw/ooo_pkg.sv
hw/issue_if.sv
hw/instruction_queue.sv
hw/issue_unit.sv
hw/register_file.sv
hw/reservation_station.sv
hw/alu.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
bench/tb_ooo_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_ooo_core -f all.f -o Vtb_ooo_core

./obj_dir/Vtb_ooo_core 2>&1 | tee sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation failed, see sim.log"
  exit 1
fi

// ==== bench/tb_ooo_core.sv ====
`timescale 1ns/1ps

module tb_ooo_core;

  localparam int words_all_ops = 22;
  localparam int words_deps = 14;
  localparam int words_nops = 8;
  localparam int words_bp = 16;
  localparam int words_random = 60;
  localparam int n_words = words_all_ops + words_deps + words_nops + words_bp + words_random;
  localparam int watchdog_cycles = n_words * 40 + 200;

  logic clk_100mhz = 1'b0;
  logic rst_n;
  logic [31:0] instruction;
  logic instruction_valid;
  logic iq_ready;
  logic commit_valid;
  logic [ooo_pkg::reg_ix_w-1:0] commit_dest;
  logic [ooo_pkg::xlen-1:0] commit_value;

  // reference model state and expected commit stream
  logic [31:0] ref_regs [32];
  logic [4:0] exp_dest [$];
  logic [31:0] exp_value [$];
  logic [4:0] got_dest;
  logic [31:0] got_value;
  logic [31:0] lfsr_state = 32'd89076;
  logic saw_not_ready;

  string test_name = "none";
  int err_count = 0;
  int err_start = 0;
  int commits_seen = 0;
  int commit_start = 0;
  int pushed = 0;
  int push_start = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  ooo_core #(.IQ_DEPTH(4), .ROB_DEPTH(8)) ooo_core_i (
    .clk_100mhz(clk_100mhz),
    .rst_n(rst_n),
    .instruction(instruction),
    .instruction_valid(instruction_valid),
    .iq_ready(iq_ready),
    .commit_valid(commit_valid),
    .commit_dest(commit_dest),
    .commit_value(commit_value)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1); // galois, right shift
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, ooo_pkg::opc_op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, ooo_pkg::opc_opimm};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, ooo_pkg::opc_lui};
  endfunction

  // rv32i semantics in program order, one expected commit per alu word
  function automatic void run_model(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [4:0] sh;
    logic is_op;
    is_op = w[6:0] == ooo_pkg::opc_op;
    a = ref_regs[w[19:15]];
    b = is_op ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    sh = b[4:0];
    case (w[14:12])
      3'b000: r = (is_op && w[30]) ? a - b : a + b;
      3'b001: r = a << sh;
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: begin
        if (w[30]) begin
          r = $signed(a) >>> sh;
        end else begin
          r = a >> sh;
        end
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    if (w[6:0] == ooo_pkg::opc_lui) begin
      r = {w[31:12], 12'b0};
    end
    if (is_op || w[6:0] == ooo_pkg::opc_opimm || w[6:0] == ooo_pkg::opc_lui) begin
      exp_dest.push_back(w[11:7]);
      exp_value.push_back(r);
      pushed++;
      if (w[11:7] != 5'd0) begin
        ref_regs[w[11:7]] = r;
      end
    end
  endfunction

  // word is held until a ready level is seen, then taken on the next edge
  task automatic send_word(input logic [31:0] word);
    @(posedge clk_100mhz);
    run_model(word);
    instruction <= word;
    instruction_valid <= 1'b1;
    @(negedge clk_100mhz);
    while (!iq_ready) begin
      saw_not_ready = 1'b1;
      @(negedge clk_100mhz);
    end
  endtask

  task automatic drain();
    @(posedge clk_100mhz);
    instruction_valid <= 1'b0;
    while (exp_dest.size() != 0) begin
      @(negedge clk_100mhz);
    end
    repeat (8) @(negedge clk_100mhz); // room for stray commits
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = err_count;
    commit_start = commits_seen;
    push_start = pushed;
  endtask

  task automatic finish_test();
    drain();
    assert (commits_seen - commit_start == pushed - push_start) else begin
      $display("CHECK FAILED %s: commit count expected %0d actual %0d", test_name,
               pushed - push_start, commits_seen - commit_start);
      err_count++;
    end
    if (err_count == err_start) begin
      tests_passed++;
      $display("test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", test_name, err_count - err_start);
    end
  endtask

  // commit monitor, sampled mid-cycle
  always @(negedge clk_100mhz) begin
    if (rst_n && commit_valid) begin
      commits_seen++;
      assert (exp_dest.size() != 0) else begin
        $display("test %s: commit to x%0d arrived with nothing pending", test_name, commit_dest);
        err_count++;
      end
      if (exp_dest.size() != 0) begin
        got_dest = exp_dest.pop_front();
        got_value = exp_value.pop_front();
        assert (commit_dest === got_dest) else begin
          $display("CHECK FAILED %s: commit dest expected %0d actual %0d", test_name,
                   got_dest, commit_dest);
          err_count++;
        end
        assert (commit_value === got_value) else begin
          $display("CHECK FAILED %s: commit value expected %h actual %h", test_name,
                   got_value, commit_value);
          err_count++;
        end
      end
    end
  end

  task automatic test_reset();
    start_test("reset");
    repeat (10) begin
      @(negedge clk_100mhz);
      assert (iq_ready === 1'b1) else begin
        $display("CHECK FAILED %s: iq_ready expected 1 actual %b", test_name, iq_ready);
        err_count++;
      end
      assert (commit_valid === 1'b0) else begin
        $display("CHECK FAILED %s: commit_valid expected 0 actual %b", test_name, commit_valid);
        err_count++;
      end
    end
    finish_test();
  endtask

  task automatic test_all_ops();
    start_test("all_ops");
    send_word(u_type(20'h80F0F, 5'd1));
    send_word(i_type(12'hFFB, 5'd0, 3'd0, 5'd2)); // -5
    send_word(i_type(12'd7, 5'd0, 3'd0, 5'd3));
    for (int f = 0; f < 8; f++) begin
      send_word(r_type(7'h00, 5'd3, 5'd2, 3'(f), 5'(4 + f)));
    end
    send_word(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd12)); // sub
    send_word(r_type(7'h20, 5'd3, 5'd2, 3'd5, 5'd13)); // sra
    for (int f = 0; f < 8; f++) begin
      if (f == 1 || f == 5) begin
        send_word(i_type((f == 1) ? 12'd5 : 12'd9, 5'd2, 3'(f), 5'(14 + f)));
      end else begin
        send_word(i_type(12'h8F3, 5'd1, 3'(f), 5'(14 + f)));
      end
    end
    send_word(i_type(12'h409, 5'd2, 3'd5, 5'd22)); // srai
    finish_test();
  endtask

  task automatic test_deps();
    start_test("dep_chain");
    send_word(i_type(12'd3, 5'd0, 3'd0, 5'd1));
    send_word(r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
    send_word(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
    send_word(r_type(7'h00, 5'd1, 5'd3, 3'd1, 5'd4));
    send_word(r_type(7'h00, 5'd2, 5'd4, 3'd4, 5'd5));
    send_word(r_type(7'h00, 5'd1, 5'd5, 3'd0, 5'd1)); // x1 renamed again
    for (int i = 0; i < 6; i++) begin
      send_word(i_type(12'(17 * (i + 1)), 5'd6, 3'd0, 5'd6));
    end
    drain(); // everything committed before the next reads
    send_word(r_type(7'h00, 5'd6, 5'd1, 3'd0, 5'd7));
    send_word(r_type(7'h00, 5'd5, 5'd7, 3'd6, 5'd8));
    finish_test();
  endtask

  task automatic test_nops();
    start_test("nop_x0");
    send_word(i_type(12'd123, 5'd1, 3'd0, 5'd0)); // commits to x0
    send_word(32'h0000_0063);
    send_word(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd9));
    send_word(32'h0000_0003);
    send_word(32'h0000_0000);
    send_word(i_type(12'hFFF, 5'd0, 3'd0, 5'd10));
    send_word(u_type(20'hABCDE, 5'd0));
    send_word(r_type(7'h20, 5'd10, 5'd0, 3'd0, 5'd11));
    finish_test();
  endtask

  task automatic test_backpressure();
    start_test("backpressure");
    saw_not_ready = 1'b0;
    for (int i = 0; i < words_bp; i++) begin
      send_word(i_type(12'(3 * i + 1), 5'd12, 3'd0, 5'd12)); // serial chain
    end
    assert (saw_not_ready) else begin
      $display("test %s: iq_ready never went low while the queue was filled", test_name);
      err_count++;
    end
    finish_test();
  endtask

  task automatic test_random();
    logic [1:0] cls;
    logic [2:0] f3;
    logic alt;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm;
    start_test("random");
    for (int n = 0; n < words_random; n++) begin
      cls = 2'(rand_bits(2));
      f3 = 3'(rand_bits(3));
      alt = 1'(rand_bits(1));
      rd = 5'(rand_bits(3));
      rs1 = 5'(rand_bits(3));
      rs2 = 5'(rand_bits(3));
      if (cls == 2'd3) begin
        send_word(u_type(20'(rand_bits(20)), rd));
      end else if (cls == 2'd2) begin
        imm = 12'(rand_bits(12));
        if (f3 == 3'd1) begin
          imm = {7'b0, imm[4:0]};
        end else if (f3 == 3'd5) begin
          imm = {1'b0, alt, 5'b0, imm[4:0]};
        end
        send_word(i_type(imm, rs1, f3, rd));
      end else begin
        send_word(r_type((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                         rs2, rs1, f3, rd));
      end
    end
    finish_test();
  endtask

  initial begin
    rst_n = 1'b0;
    instruction = '0;
    instruction_valid = 1'b0;
    saw_not_ready = 1'b0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (4) @(posedge clk_100mhz);
    rst_n <= 1'b1;
    test_reset();
    test_all_ops();
    test_deps();
    test_nops();
    test_backpressure();
    test_random();
    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    repeat (watchdog_cycles) @(posedge clk_100mhz);
    $display("watchdog expired after %0d cycles, a test is stuck in %s", watchdog_cycles,
             test_name);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== hw/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core #(
  parameter int IQ_DEPTH = 4,
  parameter int ROB_DEPTH = 8
) (
  input  logic clk_100mhz,
  input  logic rst_n,
  input  logic [31:0] instruction,
  input  logic instruction_valid,
  output logic iq_ready,
  output logic commit_valid,
  output logic [ooo_pkg::reg_ix_w-1:0] commit_dest,
  output logic [ooo_pkg::xlen-1:0] commit_value
);

  logic [31:0] head;
  logic not_empty;
  logic pop;
  logic [ooo_pkg::reg_ix_w-1:0] rs1;
  logic [ooo_pkg::reg_ix_w-1:0] rs2;
  logic [ooo_pkg::reg_ix_w-1:0] rd;
  logic alloc;
  logic rename_we;
  logic [ooo_pkg::xlen-1:0] rd1;
  logic [ooo_pkg::xlen-1:0] rd2;
  logic [ooo_pkg::rob_ix_w-1:0] tag1;
  logic [ooo_pkg::rob_ix_w-1:0] tag2;
  logic busy1;
  logic busy2;
  logic [ooo_pkg::rob_ix_w-1:0] lookup_ix1;
  logic [ooo_pkg::rob_ix_w-1:0] lookup_ix2;
  logic lookup_done1;
  logic lookup_done2;
  logic [ooo_pkg::xlen-1:0] lookup_value1;
  logic [ooo_pkg::xlen-1:0] lookup_value2;
  logic rob_free;
  logic [ooo_pkg::rob_ix_w-1:0] rob_tail;
  logic rs_free;
  logic fire;
  ooo_pkg::alu_func_e func;
  logic [ooo_pkg::xlen-1:0] op_a;
  logic [ooo_pkg::xlen-1:0] op_b;
  logic [ooo_pkg::rob_ix_w-1:0] fire_rob_ix;
  // common data bus, driven by the alu only
  logic cdb_valid;
  logic [ooo_pkg::rob_ix_w-1:0] cdb_rob_ix;
  logic [ooo_pkg::xlen-1:0] cdb_value;
  logic [ooo_pkg::rob_ix_w-1:0] commit_rob_ix;

  issue_if issue_bus ();

  instruction_queue #(.IQ_DEPTH(IQ_DEPTH)) iq_i (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n),
    .instruction(instruction), .instruction_valid(instruction_valid), .pop(pop),
    .head(head), .not_empty(not_empty), .iq_ready(iq_ready)
  );

  issue_unit issue_i (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .head(head), .not_empty(not_empty),
    .rd1(rd1), .rd2(rd2), .tag1(tag1), .tag2(tag2), .busy1(busy1), .busy2(busy2),
    .lookup_done1(lookup_done1), .lookup_done2(lookup_done2),
    .lookup_value1(lookup_value1), .lookup_value2(lookup_value2),
    .rob_free(rob_free), .rob_tail(rob_tail), .rs_free(rs_free),
    .cdb_valid(cdb_valid), .cdb_rob_ix(cdb_rob_ix), .cdb_value(cdb_value),
    .pop(pop), .rs1(rs1), .rs2(rs2), .rd(rd), .alloc(alloc), .rename_we(rename_we),
    .lookup_ix1(lookup_ix1), .lookup_ix2(lookup_ix2), .issue(issue_bus.src)
  );

  register_file rf_i (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
    .rename_we(rename_we), .rob_tail(rob_tail),
    .commit_valid(commit_valid), .commit_dest(commit_dest),
    .commit_value(commit_value), .commit_rob_ix(commit_rob_ix),
    .rd1(rd1), .rd2(rd2), .tag1(tag1), .tag2(tag2), .busy1(busy1), .busy2(busy2)
  );

  reservation_station rs_i (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .issue(issue_bus.dst),
    .cdb_valid(cdb_valid), .cdb_rob_ix(cdb_rob_ix), .cdb_value(cdb_value),
    .rs_free(rs_free), .fire(fire), .func(func), .op_a(op_a), .op_b(op_b),
    .fire_rob_ix(fire_rob_ix)
  );

  alu alu_i (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .fire(fire), .func(func),
    .op_a(op_a), .op_b(op_b), .fire_rob_ix(fire_rob_ix),
    .cdb_valid(cdb_valid), .cdb_rob_ix(cdb_rob_ix), .cdb_value(cdb_value)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob_i (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .alloc(alloc), .alloc_dest(rd),
    .cdb_valid(cdb_valid), .cdb_rob_ix(cdb_rob_ix), .cdb_value(cdb_value),
    .lookup_ix1(lookup_ix1), .lookup_ix2(lookup_ix2),
    .rob_free(rob_free), .rob_tail(rob_tail),
    .lookup_done1(lookup_done1), .lookup_done2(lookup_done2),
    .lookup_value1(lookup_value1), .lookup_value2(lookup_value2),
    .commit_valid(commit_valid), .commit_dest(commit_dest),
    .commit_value(commit_value), .commit_rob_ix(commit_rob_ix)
  );

endmodule

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer #(
  parameter int ROB_DEPTH = 8
) (
  input  logic clk_100mhz,
  input  logic rst_n,
  input  logic alloc,
  input  logic [ooo_pkg::reg_ix_w-1:0] alloc_dest,
  input  logic cdb_valid,
  input  logic [ooo_pkg::rob_ix_w-1:0] cdb_rob_ix,
  input  logic [ooo_pkg::xlen-1:0] cdb_value,
  input  logic [ooo_pkg::rob_ix_w-1:0] lookup_ix1,
  input  logic [ooo_pkg::rob_ix_w-1:0] lookup_ix2,
  output logic rob_free,
  output logic [ooo_pkg::rob_ix_w-1:0] rob_tail,
  output logic lookup_done1,
  output logic lookup_done2,
  output logic [ooo_pkg::xlen-1:0] lookup_value1,
  output logic [ooo_pkg::xlen-1:0] lookup_value2,
  output logic commit_valid,
  output logic [ooo_pkg::reg_ix_w-1:0] commit_dest,
  output logic [ooo_pkg::xlen-1:0] commit_value,
  output logic [ooo_pkg::rob_ix_w-1:0] commit_rob_ix
);

  localparam int tw = ooo_pkg::rob_ix_w;

  logic [ooo_pkg::reg_ix_w-1:0] dest_q [ROB_DEPTH];
  logic [ooo_pkg::xlen-1:0] value_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done;
  logic [tw-1:0] head;
  logic [tw-1:0] tail;
  logic [tw:0] count;
  logic [tw-1:0] cdb_dist; // bus tag distance from head

  function automatic logic [tw-1:0] next_ix(input logic [tw-1:0] ix);
    return (ix == tw'(ROB_DEPTH - 1)) ? '0 : ix + 1'b1;
  endfunction

  assign rob_free = count < (tw + 1)'(ROB_DEPTH);
  assign rob_tail = tail;

  assign lookup_done1 = done[lookup_ix1];
  assign lookup_done2 = done[lookup_ix2];
  assign lookup_value1 = value_q[lookup_ix1];
  assign lookup_value2 = value_q[lookup_ix2];

  // in-order retire, one per cycle
  assign commit_valid = count != '0 && done[head];
  assign commit_dest = dest_q[head];
  assign commit_value = value_q[head];
  assign commit_rob_ix = head;

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      done <= '0;
    end else begin
      if (alloc) begin
        done[tail] <= 1'b0;
        tail <= next_ix(tail);
      end
      if (cdb_valid) begin
        done[cdb_rob_ix] <= 1'b1;
      end
      if (commit_valid) begin
        head <= next_ix(head);
      end
      case ({alloc, commit_valid})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (alloc) begin
      dest_q[tail] <= alloc_dest;
    end
    if (cdb_valid) begin
      value_q[cdb_rob_ix] <= cdb_value;
    end
  end

  assign cdb_dist = cdb_rob_ix - head;

  // alu results only ever land on live entries
  a_cdb_live: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    cdb_valid |-> ({1'b0, cdb_dist} < count));

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic clk_100mhz,
  input  logic rst_n,
  input  logic fire,
  input  ooo_pkg::alu_func_e func,
  input  logic [ooo_pkg::xlen-1:0] op_a,
  input  logic [ooo_pkg::xlen-1:0] op_b,
  input  logic [ooo_pkg::rob_ix_w-1:0] fire_rob_ix,
  output logic cdb_valid,
  output logic [ooo_pkg::rob_ix_w-1:0] cdb_rob_ix,
  output logic [ooo_pkg::xlen-1:0] cdb_value
);

  logic [ooo_pkg::xlen-1:0] result;

  always_comb begin
    case (func)
      ooo_pkg::alu_add: result = op_a + op_b;
      ooo_pkg::alu_sub: result = op_a - op_b;
      ooo_pkg::alu_sll: result = op_a << op_b[4:0];
      ooo_pkg::alu_slt: result = {31'b0, $signed(op_a) < $signed(op_b)};
      ooo_pkg::alu_sltu: result = {31'b0, op_a < op_b};
      ooo_pkg::alu_xor: result = op_a ^ op_b;
      ooo_pkg::alu_srl: result = op_a >> op_b[4:0];
      ooo_pkg::alu_sra: result = $signed(op_a) >>> op_b[4:0];
      ooo_pkg::alu_or: result = op_a | op_b;
      ooo_pkg::alu_and: result = op_a & op_b;
      default: result = '0;
    endcase
  end

  // single-cycle pulse per fire
  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= fire;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (fire) begin
      cdb_rob_ix <= fire_rob_ix;
      cdb_value <= result;
    end
  end

endmodule

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station (
  input  logic clk_100mhz,
  input  logic rst_n,
  issue_if.dst issue,
  input  logic cdb_valid,
  input  logic [ooo_pkg::rob_ix_w-1:0] cdb_rob_ix,
  input  logic [ooo_pkg::xlen-1:0] cdb_value,
  output logic rs_free,
  output logic fire,
  output ooo_pkg::alu_func_e func,
  output logic [ooo_pkg::xlen-1:0] op_a,
  output logic [ooo_pkg::xlen-1:0] op_b,
  output logic [ooo_pkg::rob_ix_w-1:0] fire_rob_ix
);

  logic full;
  logic a_ready;
  logic b_ready;
  logic [ooo_pkg::rob_ix_w-1:0] a_tag;
  logic [ooo_pkg::rob_ix_w-1:0] b_tag;
  logic a_hit;
  logic b_hit;

  // bus snoop for operands still waiting
  assign a_hit = full && !a_ready && cdb_valid && cdb_rob_ix == a_tag;
  assign b_hit = full && !b_ready && cdb_valid && cdb_rob_ix == b_tag;

  assign rs_free = !full;
  assign fire = full && a_ready && b_ready;

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      full <= 1'b0;
      a_ready <= 1'b0;
      b_ready <= 1'b0;
    end else if (issue.valid) begin
      full <= 1'b1;
      a_ready <= issue.i_ready;
      b_ready <= issue.j_ready;
    end else begin
      if (fire) begin
        full <= 1'b0; // one-shot, free again next cycle
      end
      if (a_hit) begin
        a_ready <= 1'b1;
      end
      if (b_hit) begin
        b_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (issue.valid) begin
      func <= issue.func;
      op_a <= issue.v_i;
      op_b <= issue.v_j;
      a_tag <= issue.q_i;
      b_tag <= issue.q_j;
      fire_rob_ix <= issue.rob_ix;
    end else begin
      if (a_hit) begin
        op_a <= cdb_value;
      end
      if (b_hit) begin
        op_b <= cdb_value;
      end
    end
  end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic clk_100mhz,
  input  logic rst_n,
  input  logic [ooo_pkg::reg_ix_w-1:0] rs1,
  input  logic [ooo_pkg::reg_ix_w-1:0] rs2,
  input  logic [ooo_pkg::reg_ix_w-1:0] rd,
  input  logic rename_we,
  input  logic [ooo_pkg::rob_ix_w-1:0] rob_tail,
  input  logic commit_valid,
  input  logic [ooo_pkg::reg_ix_w-1:0] commit_dest,
  input  logic [ooo_pkg::xlen-1:0] commit_value,
  input  logic [ooo_pkg::rob_ix_w-1:0] commit_rob_ix,
  output logic [ooo_pkg::xlen-1:0] rd1,
  output logic [ooo_pkg::xlen-1:0] rd2,
  output logic [ooo_pkg::rob_ix_w-1:0] tag1,
  output logic [ooo_pkg::rob_ix_w-1:0] tag2,
  output logic busy1,
  output logic busy2
);

  logic [ooo_pkg::xlen-1:0] regs [32];
  logic [ooo_pkg::rob_ix_w-1:0] tags [32];
  logic [31:0] busy;
  logic wt1;
  logic wt2;

  // commit bypass on each read port
  assign wt1 = commit_valid && commit_dest == rs1;
  assign wt2 = commit_valid && commit_dest == rs2;

  assign rd1 = (rs1 == '0) ? '0 : wt1 ? commit_value : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : wt2 ? commit_value : regs[rs2];
  assign tag1 = tags[rs1];
  assign tag2 = tags[rs2];
  // still busy unless the committing entry is the latest producer
  assign busy1 = rs1 != '0 && busy[rs1] && !(wt1 && commit_rob_ix == tags[rs1]);
  assign busy2 = rs2 != '0 && busy[rs2] && !(wt2 && commit_rob_ix == tags[rs2]);

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      busy <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit_valid && commit_dest != '0) begin
        regs[commit_dest] <= commit_value;
        if (tags[commit_dest] == commit_rob_ix) begin
          busy[commit_dest] <= 1'b0;
        end
      end
      if (rename_we) begin
        busy[rd] <= 1'b1; // overrides a clear in the same cycle
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (rename_we) begin
      tags[rd] <= rob_tail;
    end
  end

endmodule

// ==== hw/issue_unit.sv ====
`timescale 1ns/1ps

module issue_unit (
  input  logic clk_100mhz,
  input  logic rst_n,
  input  logic [31:0] head,
  input  logic not_empty,
  input  logic [ooo_pkg::xlen-1:0] rd1,
  input  logic [ooo_pkg::xlen-1:0] rd2,
  input  logic [ooo_pkg::rob_ix_w-1:0] tag1,
  input  logic [ooo_pkg::rob_ix_w-1:0] tag2,
  input  logic busy1,
  input  logic busy2,
  input  logic lookup_done1,
  input  logic lookup_done2,
  input  logic [ooo_pkg::xlen-1:0] lookup_value1,
  input  logic [ooo_pkg::xlen-1:0] lookup_value2,
  input  logic rob_free,
  input  logic [ooo_pkg::rob_ix_w-1:0] rob_tail,
  input  logic rs_free,
  input  logic cdb_valid,
  input  logic [ooo_pkg::rob_ix_w-1:0] cdb_rob_ix,
  input  logic [ooo_pkg::xlen-1:0] cdb_value,
  output logic pop,
  output logic [ooo_pkg::reg_ix_w-1:0] rs1,
  output logic [ooo_pkg::reg_ix_w-1:0] rs2,
  output logic [ooo_pkg::reg_ix_w-1:0] rd,
  output logic alloc,
  output logic rename_we,
  output logic [ooo_pkg::rob_ix_w-1:0] lookup_ix1,
  output logic [ooo_pkg::rob_ix_w-1:0] lookup_ix2,
  issue_if.src issue
);

  ooo_pkg::itype_e itype;
  ooo_pkg::alu_func_e func;
  logic [ooo_pkg::xlen-1:0] imm;
  logic [ooo_pkg::xlen:0] src1; // {ready, value}
  logic [ooo_pkg::xlen:0] src2;

  // register value, then finished rob entry, then this cycle's bus, else wait
  function automatic logic [ooo_pkg::xlen:0] resolve(
    input logic busy,
    input logic [ooo_pkg::xlen-1:0] reg_val,
    input logic done,
    input logic [ooo_pkg::xlen-1:0] rob_val,
    input logic [ooo_pkg::rob_ix_w-1:0] tag
  );
    return !busy ? {1'b1, reg_val} :
           done ? {1'b1, rob_val} :
           (cdb_valid && cdb_rob_ix == tag) ? {1'b1, cdb_value} : {1'b0, reg_val};
  endfunction

  always_comb begin
    case (head[6:0])
      ooo_pkg::opc_op: itype = ooo_pkg::it_op;
      ooo_pkg::opc_opimm: itype = ooo_pkg::it_opimm;
      ooo_pkg::opc_lui: itype = ooo_pkg::it_lui;
      default: itype = ooo_pkg::it_nop; // anything else is dropped
    endcase
    func = ooo_pkg::alu_add; // lui is 0 + imm
    if (itype == ooo_pkg::it_op || itype == ooo_pkg::it_opimm) begin
      case (head[14:12])
        3'b000: func = (itype == ooo_pkg::it_op && head[30]) ? ooo_pkg::alu_sub
                                                            : ooo_pkg::alu_add;
        3'b001: func = ooo_pkg::alu_sll;
        3'b010: func = ooo_pkg::alu_slt;
        3'b011: func = ooo_pkg::alu_sltu;
        3'b100: func = ooo_pkg::alu_xor;
        3'b101: func = head[30] ? ooo_pkg::alu_sra : ooo_pkg::alu_srl;
        3'b110: func = ooo_pkg::alu_or;
        default: func = ooo_pkg::alu_and;
      endcase
    end
  end

  assign imm = (itype == ooo_pkg::it_lui) ? {head[31:12], 12'b0}
                                          : {{20{head[31]}}, head[31:20]};
  assign rs1 = (itype == ooo_pkg::it_lui) ? '0 : head[19:15];
  assign rs2 = head[24:20];
  assign rd = head[11:7];
  assign lookup_ix1 = tag1;
  assign lookup_ix2 = tag2;

  always_comb begin
    src1 = resolve(busy1, rd1, lookup_done1, lookup_value1, tag1);
    if (itype == ooo_pkg::it_op) begin
      src2 = resolve(busy2, rd2, lookup_done2, lookup_value2, tag2);
    end else begin
      src2 = {1'b1, imm}; // immediate is always ready
    end
  end

  assign alloc = not_empty && itype != ooo_pkg::it_nop && rob_free && rs_free;
  assign pop = alloc || (not_empty && itype == ooo_pkg::it_nop);
  assign rename_we = alloc && rd != '0; // x0 never renamed

  assign issue.valid = alloc;
  assign issue.func = func;
  assign issue.v_i = src1[ooo_pkg::xlen-1:0];
  assign issue.v_j = src2[ooo_pkg::xlen-1:0];
  assign issue.i_ready = src1[ooo_pkg::xlen];
  assign issue.j_ready = src2[ooo_pkg::xlen];
  assign issue.q_i = tag1;
  assign issue.q_j = tag2;
  assign issue.rob_ix = rob_tail;

  // station is occupied for at least the cycle after it takes an entry
  a_issue_rs_free: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    issue.valid |=> !issue.valid);

endmodule

// ==== hw/instruction_queue.sv ====
`timescale 1ns/1ps

module instruction_queue #(
  parameter int IQ_DEPTH = 4
) (
  input  logic clk_100mhz,
  input  logic rst_n,
  input  logic [31:0] instruction,
  input  logic instruction_valid,
  input  logic pop,
  output logic [31:0] head,
  output logic not_empty,
  output logic iq_ready
);

  localparam int pw = $clog2(IQ_DEPTH);

  logic [31:0] mem [IQ_DEPTH];
  logic [pw-1:0] wr_ptr;
  logic [pw-1:0] rd_ptr;
  logic [pw:0] count;
  logic push;

  assign iq_ready = count < (pw + 1)'(IQ_DEPTH);
  assign not_empty = count != '0;
  assign push = instruction_valid && iq_ready; // strobe while full is dropped
  assign head = mem[rd_ptr];

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == pw'(IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == pw'(IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (push) begin
      mem[wr_ptr] <= instruction;
    end
  end

  // issue side must only pop what is there
  a_no_pop_empty: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    pop |-> not_empty);

endmodule

// ==== hw/issue_if.sv ====
`timescale 1ns/1ps

interface issue_if;
  logic valid; // one-cycle issue strobe
  ooo_pkg::alu_func_e func;
  logic [ooo_pkg::xlen-1:0] v_i;
  logic [ooo_pkg::xlen-1:0] v_j;
  logic [ooo_pkg::rob_ix_w-1:0] q_i; // producer tag when not ready
  logic [ooo_pkg::rob_ix_w-1:0] q_j;
  logic i_ready;
  logic j_ready;
  logic [ooo_pkg::rob_ix_w-1:0] rob_ix; // destination entry

  modport src (
    output valid, func, v_i, v_j, q_i, q_j, i_ready, j_ready, rob_ix
  );

  modport dst (
    input valid, func, v_i, v_j, q_i, q_j, i_ready, j_ready, rob_ix
  );
endinterface

// ==== hw/ooo_pkg.sv ====
package ooo_pkg;

  localparam int xlen = 32;
  localparam int reg_ix_w = 5;
  localparam int rob_ix_w = 3; // log2 of the rob depth

  // rv32i major opcodes
  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_opimm = 7'b0010011;
  localparam logic [6:0] opc_lui = 7'b0110111;

  typedef enum logic [1:0] {
    it_op,
    it_opimm,
    it_lui,
    it_nop
  } itype_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_func_e;

endpackage
